// ==== core.f ====
src/core_pkg.sv
src/pipe_if.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memwb.sv
src/core.sv
tb/tb_clock.sv
tb/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/core_tb.sv ====
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 4;
    localparam logic [15:0] RESET_PC     = 16'h0010;
    // Rough count of instructions executed by all tests, with some slack
    localparam int          TOTAL_INSTR  = 140;

    logic        clk;
    logic        i_reset;
    logic [15:0] o_req_addr;
    logic        o_req_submit;
    logic [31:0] i_req_data;
    logic        i_req_data_valid;
    logic [15:0] o_mem_addr;
    logic [15:0] o_mem_data;
    logic [15:0] i_mem_data;
    logic        o_mem_req;
    logic        o_mem_we;
    logic        i_mem_ack;
    logic [15:0] o_dbg_pc;
    logic [15:0] o_dbg_r0;

    logic [31:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] next_pc;
    logic        delays_on;
    logic [15:0] lfsr;
    int          errors;
    int          checks;

    // Bus model state
    logic        fetch_busy;
    logic [15:0] fetch_addr;
    int          fetch_wait;
    logic        data_busy;
    int          data_wait;
    logic        ack_was;

    tb_clock #(.PERIOD(CLK_PERIOD)) clock_gen (.o_clk(clk));

    core #(.RESET_PC(RESET_PC)) i_core (
        .i_clk(clk), .i_reset(i_reset),
        .o_req_addr(o_req_addr), .o_req_submit(o_req_submit),
        .i_req_data(i_req_data), .i_req_data_valid(i_req_data_valid),
        .o_mem_addr(o_mem_addr), .o_mem_data(o_mem_data), .i_mem_data(i_mem_data),
        .o_mem_req(o_mem_req), .o_mem_we(o_mem_we), .i_mem_ack(i_mem_ack),
        .o_dbg_pc(o_dbg_pc), .o_dbg_r0(o_dbg_r0)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int random_delay();
        int d;
        d = 0;
        if (delays_on) begin
            repeat (2) d = (d << 1) | int'(next_bit());
        end
        return d;
    endfunction

    function automatic logic [15:0] fill_word(input logic [7:0] a);
        return {~a, a};
    endfunction

    function automatic logic [31:0] encode_reg(input logic [3:0] op, input int rd, input int rs,
                                               input logic [15:0] imm);
        return {imm, op, rd[2:0], rs[2:0], 6'b0};
    endfunction

    function automatic logic [31:0] encode_alui(input logic [2:0] mode, input int rd,
                                                input logic [15:0] imm);
        return {imm, ALUI, rd[2:0], 3'b0, mode, 3'b0};
    endfunction

    function automatic logic [31:0] encode_jump(input logic [1:0] cond, input logic [15:0] target);
        return {target, JMP, cond, 10'b0};
    endfunction

    // Both buses in one process so the LFSR is stepped in a fixed order
    always @(negedge clk) begin
        i_req_data_valid = 1'b0;
        ack_was = i_mem_ack;
        i_mem_ack = 1'b0;
        if (i_reset) begin
            fetch_busy = 1'b0;
            data_busy  = 1'b0;
        end else begin
            if (o_req_submit) begin
                fetch_busy = 1'b1;
                fetch_addr = o_req_addr;
                fetch_wait = random_delay();
            end
            if (fetch_busy) begin
                if (fetch_wait == 0) begin
                    i_req_data       = imem[fetch_addr[7:0]];
                    i_req_data_valid = 1'b1;
                    fetch_busy       = 1'b0;
                end else begin
                    fetch_wait = fetch_wait - 1;
                end
            end
            if (o_mem_req && !data_busy && !ack_was) begin
                data_busy = 1'b1;
                data_wait = random_delay();
            end
            if (data_busy) begin
                if (data_wait == 0) begin
                    if (o_mem_we) begin
                        dmem[o_mem_addr[7:0]] = o_mem_data;
                    end else begin
                        i_mem_data = dmem[o_mem_addr[7:0]];
                    end
                    i_mem_ack = 1'b1;
                    data_busy = 1'b0;
                end else begin
                    data_wait = data_wait - 1;
                end
            end
        end
    end

    task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic new_program(input logic with_delays);
        for (int a = 0; a < 256; a++) begin
            imem[a[7:0]] = '0;
            dmem[a[7:0]] = fill_word(a[7:0]);
        end
        next_pc   = RESET_PC;
        delays_on = with_delays;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[next_pc[7:0]] = word;
        next_pc = next_pc + 16'd1;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        i_reset = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_word("o_req_submit", 16'(o_req_submit), 16'h0000);
            check_word("o_mem_req", 16'(o_mem_req), 16'h0000);
        end
        i_reset = 1'b0;
    endtask

    // Ends the program with a jump to itself and runs until execute sits on it
    task automatic run_program();
        logic [15:0] halt_pc;
        int          quiet;
        halt_pc = next_pc;
        emit(encode_jump(ALWAYS, halt_pc));
        apply_reset();
        while (o_dbg_pc !== halt_pc) @(negedge clk);
        // Stores and writebacks behind the halt jump still drain
        quiet = 0;
        while (quiet < 3) begin
            @(negedge clk);
            quiet = o_mem_req ? 0 : quiet + 1;
        end
    endtask

    task automatic alu_chain();
        logic [15:0] a;
        logic [15:0] b;
        logic        carry;
        new_program(1'b0);
        emit(encode_alui(ALU_MOV, 1, 16'hFFF0));
        emit(encode_alui(ALU_MOV, 2, 16'h0025));
        emit(encode_reg(ADD, 1, 2, 16'h0));
        emit(encode_reg(ADC, 2, 1, 16'h0));
        emit(encode_reg(SUB, 2, 1, 16'h0));
        emit(encode_reg(XOR, 1, 2, 16'h0));
        emit(encode_alui(ALU_AND, 1, 16'h00F1));
        emit(encode_reg(OR, 1, 2, 16'h0));
        emit(encode_alui(ALU_SUB, 1, 16'h0040));
        emit(encode_alui(ALU_MOV, 3, 16'h0000));
        emit(encode_reg(ADC, 1, 3, 16'h0));
        emit(encode_alui(ALU_XOR, 1, 16'h1234));
        emit(encode_reg(MOV, 0, 1, 16'h0));
        run_program();
        a = 16'hFFF0;
        b = 16'h0025;
        {carry, a} = {1'b0, a} + {1'b0, b};
        {carry, b} = {1'b0, b} + {1'b0, a} + {16'b0, carry};
        b = b - a;
        a = a ^ b;
        a = a & 16'h00F1;
        a = a | b;
        // Borrow lands in the carry flag, then ADC adds it with a zero register
        {carry, a} = {1'b0, a} - 17'h00040;
        a = a + {15'b0, carry};
        a = a ^ 16'h1234;
        check_word("o_dbg_r0", o_dbg_r0, a);
    endtask

    task automatic load_store();
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] v3;
        new_program(1'b1);
        emit(encode_alui(ALU_MOV, 1, 16'h0040));
        emit(encode_alui(ALU_MOV, 2, 16'h1111));
        emit(encode_reg(ST, 2, 1, 16'h0000));
        emit(encode_alui(ALU_ADD, 2, 16'h2222));
        emit(encode_reg(ST, 2, 1, 16'h0005));
        emit(encode_reg(LD, 3, 1, 16'h0000));
        emit(encode_reg(LD, 4, 1, 16'h0005));
        emit(encode_reg(ADD, 3, 4, 16'h0));
        emit(encode_reg(ST, 3, 1, 16'h0009));
        emit(encode_reg(LD, 0, 1, 16'h0009));
        emit(encode_reg(LD, 5, 1, 16'h0020));
        emit(encode_reg(ADD, 0, 5, 16'h0));
        run_program();
        v1 = 16'h1111;
        v2 = v1 + 16'h2222;
        v3 = v1 + v2;
        check_word("dmem[40]", dmem[8'h40], v1);
        check_word("dmem[45]", dmem[8'h45], v2);
        check_word("dmem[49]", dmem[8'h49], v3);
        check_word("o_dbg_r0", o_dbg_r0, v3 + fill_word(8'h60));
    endtask

    // Wrong-path instructions set high bits of r0
    task automatic jump_conditions();
        new_program(1'b0);
        emit(encode_alui(ALU_MOV, 0, 16'h0000));
        emit(encode_jump(ALWAYS, RESET_PC + 16'd3));
        emit(encode_alui(ALU_OR, 0, 16'h8000));
        emit(encode_alui(ALU_MOV, 1, 16'h0000));
        emit(encode_alui(ALU_OR, 1, 16'h0000));
        emit(encode_jump(NZERO, RESET_PC + 16'd15));
        emit(encode_jump(ZERO, RESET_PC + 16'd8));
        emit(encode_alui(ALU_OR, 0, 16'h4000));
        emit(encode_alui(ALU_OR, 0, 16'h0001));
        emit(encode_jump(ZERO, RESET_PC + 16'd15));
        emit(encode_jump(CARRY, RESET_PC + 16'd15));
        emit(encode_jump(NZERO, RESET_PC + 16'd13));
        emit(encode_alui(ALU_OR, 0, 16'h2000));
        emit(encode_alui(ALU_SUB, 1, 16'h0001));
        emit(encode_jump(CARRY, RESET_PC + 16'd17));
        emit(encode_alui(ALU_OR, 0, 16'h1000));
        emit(encode_jump(ALWAYS, RESET_PC + 16'd17));
        emit(encode_alui(ALU_OR, 0, 16'h0002));
        run_program();
        check_word("o_dbg_r0", o_dbg_r0, 16'h0001 | 16'h0002);
    endtask

    // Same loop without and with bus delays
    task automatic back_pressure();
        logic [15:0] sum;
        logic [15:0] i;
        logic [7:0]  a;
        for (int pass = 0; pass < 2; pass++) begin
            new_program(pass == 1);
            emit(encode_alui(ALU_MOV, 1, 16'h0000));
            emit(encode_alui(ALU_MOV, 2, 16'h0080));
            emit(encode_alui(ALU_MOV, 0, 16'h0000));
            emit(encode_reg(ST, 1, 2, 16'h0000));
            emit(encode_reg(LD, 3, 2, 16'h0000));
            emit(encode_reg(ADD, 0, 3, 16'h0));
            emit(encode_alui(ALU_ADD, 2, 16'h0001));
            emit(encode_alui(ALU_ADD, 1, 16'h0003));
            emit(encode_reg(MOV, 4, 1, 16'h0));
            emit(encode_alui(ALU_SUB, 4, 16'h000F));
            emit(encode_jump(NZERO, RESET_PC + 16'd3));
            run_program();
            sum = '0;
            i   = '0;
            a   = 8'h80;
            do begin
                check_word($sformatf("dmem[%02h]", a), dmem[a], i);
                sum = sum + i;
                i   = i + 16'd3;
                a   = a + 8'd1;
            end while (i != 16'd15);
            check_word("o_dbg_r0", o_dbg_r0, sum);
        end
    endtask

    task automatic reset_values();
        int n;
        new_program(1'b0);
        emit(encode_jump(ALWAYS, RESET_PC));
        apply_reset();
        check_word("o_dbg_r0", o_dbg_r0, 16'h0000);
        check_word("o_dbg_pc", o_dbg_pc, 16'h0000);
        n = 0;
        while (o_req_submit !== 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (o_req_submit !== 1'b1) begin
            errors++;
            $display("%0t ns: no instruction request came after reset", $time);
        end else begin
            check_word("o_req_addr", o_req_addr, RESET_PC);
        end
    endtask

    initial begin
        #(TOTAL_INSTR * 40 * CLK_PERIOD);
        $display("Watchdog: the tests did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        i_reset          = 1'b1;
        i_req_data       = '0;
        i_req_data_valid = 1'b0;
        i_mem_data       = '0;
        i_mem_ack        = 1'b0;
        fetch_busy       = 1'b0;
        data_busy        = 1'b0;
        delays_on        = 1'b0;
        lfsr             = 16'd58684;
        errors           = 0;
        checks           = 0;
        alu_chain();
        load_store();
        jump_conditions();
        back_pressure();
        // Last, so r0 starts nonzero
        reset_values();
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== src/core.sv ====
`default_nettype none

module core #(
    parameter logic [core_pkg::RW-1:0] RESET_PC = '0
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    output logic [core_pkg::RW-1:0]     o_req_addr,
    output logic                        o_req_submit,
    input  logic [core_pkg::I_SIZE-1:0] i_req_data,
    input  logic                        i_req_data_valid,
    output logic [core_pkg::RW-1:0]     o_mem_addr,
    output logic [core_pkg::RW-1:0]     o_mem_data,
    input  logic [core_pkg::RW-1:0]     i_mem_data,
    output logic                        o_mem_req,
    output logic                        o_mem_we,
    input  logic                        i_mem_ack,
    output logic [core_pkg::RW-1:0]     o_dbg_pc,
    output logic [core_pkg::RW-1:0]     o_dbg_r0
);
    import core_pkg::*;

    logic              fd_submit;
    logic              fd_ready;
    logic [I_SIZE-1:0] fd_instr;
    logic [RW-1:0]     fd_pc;
    logic              flush;
    logic [RW-1:0]     jump_pc;
    logic [REGNO-1:0]  wb_reg_ie;
    logic [RW-1:0]     wb_data;

    de_if de ();
    ew_if ew ();

    fetch #(.RESET_PC(RESET_PC)) fetch (
        .i_clk(i_clk), .i_reset(i_reset),
        .o_req_addr(o_req_addr), .o_req_submit(o_req_submit),
        .i_req_data(i_req_data), .i_req_data_valid(i_req_data_valid),
        .i_next_ready(fd_ready), .o_submit(fd_submit), .o_instr(fd_instr), .o_pc(fd_pc),
        .i_flush(flush), .i_jump_pc(jump_pc)
    );

    decode decode (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_submit(fd_submit), .o_ready(fd_ready), .i_instr(fd_instr), .i_pc(fd_pc),
        .i_flush(flush), .de(de.decode)
    );

    execute execute (
        .i_clk(i_clk), .i_reset(i_reset), .de(de.execute), .ew(ew.execute),
        .i_wb_reg_ie(wb_reg_ie), .i_wb_data(wb_data),
        .o_flush(flush), .o_jump_pc(jump_pc), .o_dbg_pc(o_dbg_pc), .o_dbg_r0(o_dbg_r0)
    );

    memwb memwb (
        .i_clk(i_clk), .i_reset(i_reset), .ew(ew.memwb),
        .o_wb_reg_ie(wb_reg_ie), .o_wb_data(wb_data),
        .o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr), .o_mem_data(o_mem_data),
        .o_mem_we(o_mem_we), .i_mem_data(i_mem_data), .i_mem_ack(i_mem_ack)
    );

endmodule

`default_nettype wire

// ==== src/memwb.sv ====
`default_nettype none

module memwb (
    input  logic                       i_clk,
    input  logic                       i_reset,
    ew_if.memwb                        ew,
    output logic [core_pkg::REGNO-1:0] o_wb_reg_ie,
    output logic [core_pkg::RW-1:0]    o_wb_data,
    output logic                       o_mem_req,
    output logic [core_pkg::RW-1:0]    o_mem_addr,
    output logic [core_pkg::RW-1:0]    o_mem_data,
    output logic                       o_mem_we,
    input  logic [core_pkg::RW-1:0]    i_mem_data,
    input  logic                       i_mem_ack
);
    import core_pkg::*;

    logic             full;
    logic             done;
    logic             mem_access;
    logic [REGNO-1:0] reg_ie;
    logic [RW-1:0]    data;
    logic             take;
    logic             leaving;
    logic             acked;

    assign leaving     = full & (~mem_access | done);
    assign ew.ready    = ~full | leaving;
    assign take        = ew.submit & ew.ready;
    assign acked       = o_mem_req & i_mem_ack;
    assign o_wb_reg_ie = leaving ? reg_ie : '0;
    assign o_wb_data   = data;
    assign o_mem_data  = data;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            full      <= 1'b0;
            done      <= 1'b0;
            o_mem_req <= 1'b0;
            o_mem_we  <= 1'b0;
        end else if (take) begin
            full      <= 1'b1;
            done      <= 1'b0;
            o_mem_req <= ew.mem_access;
            o_mem_we  <= ew.mem_access & ew.mem_we;
        end else begin
            if (leaving) begin
                full <= 1'b0;
            end
            if (acked) begin
                o_mem_req <= 1'b0;
                o_mem_we  <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            data       <= ew.data;
            o_mem_addr <= ew.addr;
            reg_ie     <= ew.reg_ie;
            mem_access <= ew.mem_access;
        end else if (acked && !o_mem_we) begin
            // Load result, written back next cycle
            data <= i_mem_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/execute.sv ====
`default_nettype none

module execute (
    input  logic                       i_clk,
    input  logic                       i_reset,
    de_if.execute                      de,
    ew_if.execute                      ew,
    input  logic [core_pkg::REGNO-1:0] i_wb_reg_ie,
    input  logic [core_pkg::RW-1:0]    i_wb_data,
    output logic                       o_flush,
    output logic [core_pkg::RW-1:0]    o_jump_pc,
    output logic [core_pkg::RW-1:0]    o_dbg_pc,
    output logic [core_pkg::RW-1:0]    o_dbg_r0
);
    import core_pkg::*;

    logic [RW-1:0]    regs [REGNO];
    logic             flag_z;
    logic             flag_c;
    logic [REGNO-1:0] pending;
    logic [REGNO-1:0] read_mask;
    logic             hazard;
    logic             accept;
    logic [RW-1:0]    l_val;
    logic [RW-1:0]    r_val;
    logic [RW-1:0]    r_op;
    logic [RW-1:0]    alu_res;
    logic             alu_c;
    logic             cond_ok;
    logic             jump_taken;

    assign l_val    = regs[de.ctrl.l_reg_sel];
    assign r_val    = regs[de.ctrl.r_reg_sel];
    assign r_op     = de.ctrl.r_bus_imm ? de.imm : r_val;
    assign o_dbg_r0 = regs[0];

    // Registers with a write still in flight
    // Destination included to avoid WAW
    always_comb begin
        read_mask = '0;
        if (de.ctrl.used_operands[0]) begin
            read_mask[de.ctrl.l_reg_sel] = 1'b1;
        end
        if (de.ctrl.used_operands[1]) begin
            read_mask[de.ctrl.r_reg_sel] = 1'b1;
        end
    end

    assign hazard   = |(pending & (read_mask | de.ctrl.rf_ie));
    assign de.ready = ~o_flush & ~hazard & (~ew.submit | ew.ready);
    assign accept   = de.submit & de.ready;

    always_comb begin
        alu_c   = 1'b0;
        alu_res = r_op;
        case (de.ctrl.alu_mode)
            ALU_ADD: {alu_c, alu_res} = {1'b0, l_val} + {1'b0, r_op}
                                      + {{RW{1'b0}}, de.ctrl.carry_en & flag_c};
            // Carry set on borrow
            ALU_SUB: {alu_c, alu_res} = {1'b0, l_val} - {1'b0, r_op};
            ALU_AND: alu_res = l_val & r_op;
            ALU_OR:  alu_res = l_val | r_op;
            ALU_XOR: alu_res = l_val ^ r_op;
            default: alu_res = r_op;
        endcase
    end

    always_comb begin
        case (de.ctrl.jump_cond)
            ALWAYS:  cond_ok = 1'b1;
            ZERO:    cond_ok = flag_z;
            NZERO:   cond_ok = ~flag_z;
            default: cond_ok = flag_c;
        endcase
    end

    assign jump_taken = accept & de.ctrl.jump_en & cond_ok;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            regs <= '{default: '0};
        end else begin
            for (int i = 0; i < REGNO; i++) begin
                if (i_wb_reg_ie[i]) begin
                    regs[i] <= i_wb_data;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            flag_z    <= 1'b0;
            flag_c    <= 1'b0;
            pending   <= '0;
            o_flush   <= 1'b0;
            o_dbg_pc  <= '0;
            ew.submit <= 1'b0;
        end else begin
            pending <= (pending & ~i_wb_reg_ie) | (accept ? de.ctrl.rf_ie : '0);
            o_flush <= jump_taken;
            if (accept && de.ctrl.flags_ie) begin
                flag_z <= (alu_res == '0);
                flag_c <= alu_c;
            end
            if (accept) begin
                o_dbg_pc  <= de.pc;
                // Jumps and nops end here
                ew.submit <= |de.ctrl.rf_ie | de.ctrl.mem_access;
            end else if (ew.ready) begin
                ew.submit <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            ew.data       <= de.ctrl.mem_we ? r_val : alu_res;
            ew.addr       <= alu_res;
            ew.reg_ie     <= de.ctrl.rf_ie;
            ew.mem_access <= de.ctrl.mem_access;
            ew.mem_we     <= de.ctrl.mem_we;
        end
        if (jump_taken) begin
            o_jump_pc <= de.imm;
        end
    end

endmodule

`default_nettype wire

// ==== src/decode.sv ====
`default_nettype none

module decode (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_submit,
    output logic                        o_ready,
    input  logic [core_pkg::I_SIZE-1:0] i_instr,
    input  logic [core_pkg::RW-1:0]     i_pc,
    input  logic                        i_flush,
    de_if.decode                        de
);
    import core_pkg::*;

    instr_lo_t    lo;
    decode_ctrl_t nxt;
    logic         take;

    assign lo      = i_instr[15:0];
    assign o_ready = ~i_flush & (~de.submit | de.ready);
    assign take    = i_submit & o_ready;

    always_comb begin
        nxt = '0;
        case (lo.rform.opcode)
            ADD, ADC, SUB, AND, OR, XOR: begin
                nxt.l_reg_sel     = lo.rform.rd;
                nxt.r_reg_sel     = lo.rform.rs;
                nxt.carry_en      = (lo.rform.opcode == ADC);
                nxt.flags_ie      = 1'b1;
                nxt.rf_ie         = REGNO'(1) << lo.rform.rd;
                nxt.used_operands = 2'b11;
                case (lo.rform.opcode)
                    SUB:     nxt.alu_mode = ALU_SUB;
                    AND:     nxt.alu_mode = ALU_AND;
                    OR:      nxt.alu_mode = ALU_OR;
                    XOR:     nxt.alu_mode = ALU_XOR;
                    default: nxt.alu_mode = ALU_ADD;
                endcase
            end
            MOV: begin
                nxt.r_reg_sel     = lo.rform.rs;
                nxt.alu_mode      = ALU_MOV;
                nxt.rf_ie         = REGNO'(1) << lo.rform.rd;
                nxt.used_operands = 2'b10;
            end
            ALUI: begin
                nxt.l_reg_sel     = lo.rform.rd;
                nxt.r_bus_imm     = 1'b1;
                nxt.alu_mode      = lo.rform.mode;
                nxt.flags_ie      = (lo.rform.mode != ALU_MOV);
                nxt.rf_ie         = REGNO'(1) << lo.rform.rd;
                nxt.used_operands = (lo.rform.mode == ALU_MOV) ? 2'b00 : 2'b01;
            end
            LD, ST: begin
                // Address is rs plus immediate
                // Store data comes from rd
                nxt.l_reg_sel     = lo.rform.rs;
                nxt.r_reg_sel     = lo.rform.rd;
                nxt.r_bus_imm     = 1'b1;
                nxt.alu_mode      = ALU_ADD;
                nxt.mem_access    = 1'b1;
                nxt.mem_we        = (lo.rform.opcode == ST);
                nxt.rf_ie         = (lo.rform.opcode == LD) ? REGNO'(1) << lo.rform.rd : '0;
                nxt.used_operands = (lo.rform.opcode == ST) ? 2'b11 : 2'b01;
            end
            JMP: begin
                nxt.jump_en   = 1'b1;
                nxt.jump_cond = lo.jform.cond;
            end
            default: nxt = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            de.submit <= 1'b0;
        end else if (i_flush) begin
            de.submit <= 1'b0;
        end else if (take) begin
            de.submit <= 1'b1;
        end else if (de.ready) begin
            de.submit <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            de.ctrl <= nxt;
            de.imm  <= i_instr[I_SIZE-1:16];
            de.pc   <= i_pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch.sv ====
`default_nettype none

module fetch #(
    parameter logic [core_pkg::RW-1:0] RESET_PC = '0
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    output logic [core_pkg::RW-1:0]     o_req_addr,
    output logic                        o_req_submit,
    input  logic [core_pkg::I_SIZE-1:0] i_req_data,
    input  logic                        i_req_data_valid,
    input  logic                        i_next_ready,
    output logic                        o_submit,
    output logic [core_pkg::I_SIZE-1:0] o_instr,
    output logic [core_pkg::RW-1:0]     o_pc,
    input  logic                        i_flush,
    input  logic [core_pkg::RW-1:0]     i_jump_pc
);
    import core_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_HOLD} fetch_state_t;

    fetch_state_t  state;
    logic [RW-1:0] pc;
    logic          drop;
    logic          issue;
    logic          capture;

    assign issue   = ~i_flush & ((state == S_IDLE) | ((state == S_HOLD) & i_next_ready));
    assign capture = ~i_flush & (state == S_WAIT) & i_req_data_valid & ~drop;
    assign o_submit = (state == S_HOLD);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= S_IDLE;
            pc           <= RESET_PC;
            drop         <= 1'b0;
            o_req_submit <= 1'b0;
        end else begin
            o_req_submit <= issue;
            if (i_flush) begin
                pc <= i_jump_pc;
                // Response still on its way
                // Thrown away when it lands
                if ((state == S_WAIT) && !i_req_data_valid) begin
                    drop <= 1'b1;
                end else begin
                    drop  <= 1'b0;
                    state <= S_IDLE;
                end
            end else if (issue) begin
                state <= S_WAIT;
            end else if ((state == S_WAIT) && i_req_data_valid) begin
                drop <= 1'b0;
                if (drop) begin
                    state <= S_IDLE;
                end else begin
                    state <= S_HOLD;
                    pc    <= pc + RW'(1);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_req_addr <= pc;
        end
        if (capture) begin
            o_instr <= i_req_data;
            o_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/pipe_if.sv ====
`default_nettype none

interface de_if;
    import core_pkg::*;

    logic          submit;
    logic          ready;
    decode_ctrl_t  ctrl;
    logic [RW-1:0] imm;
    logic [RW-1:0] pc;

    modport decode (
        output submit, ctrl, imm, pc,
        input  ready
    );

    modport execute (
        input  submit, ctrl, imm, pc,
        output ready
    );
endinterface

interface ew_if;
    import core_pkg::*;

    logic             submit;
    logic             ready;
    logic [RW-1:0]    data;
    logic [RW-1:0]    addr;
    logic [REGNO-1:0] reg_ie;
    logic             mem_access;
    logic             mem_we;

    modport execute (
        output submit, data, addr, reg_ie, mem_access, mem_we,
        input  ready
    );

    modport memwb (
        input  submit, data, addr, reg_ie, mem_access, mem_we,
        output ready
    );
endinterface

`default_nettype wire

// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int RW        = 16;
    localparam int I_SIZE    = 32;
    localparam int REGNO     = 8;
    localparam int REGNO_LOG = 3;

    typedef enum logic [3:0] {
        NOP, ADD, ADC, SUB, AND, OR, XOR, MOV, ALUI, LD, ST, JMP
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MOV
    } alu_mode_t;

    typedef enum logic [1:0] {
        ALWAYS, ZERO, NZERO, CARRY
    } jump_cond_t;

    // Low instruction half
    // Opcode always in the top nibble
    typedef union packed {
        struct packed {
            opcode_t               opcode;
            logic [REGNO_LOG-1:0]  rd;
            logic [REGNO_LOG-1:0]  rs;
            alu_mode_t             mode;
            logic [2:0]            spare;
        } rform;
        struct packed {
            opcode_t               opcode;
            jump_cond_t            cond;
            logic [9:0]            spare;
        } jform;
    } instr_lo_t;

    typedef struct packed {
        logic [REGNO_LOG-1:0]  l_reg_sel;
        logic [REGNO_LOG-1:0]  r_reg_sel;
        logic                  r_bus_imm;
        alu_mode_t             alu_mode;
        logic                  carry_en;
        logic                  flags_ie;
        logic [REGNO-1:0]      rf_ie;
        logic                  jump_en;
        jump_cond_t            jump_cond;
        logic                  mem_access;
        logic                  mem_we;
        // bit 0 left operand, bit 1 right operand
        logic [1:0]            used_operands;
    } decode_ctrl_t;

endpackage

`default_nettype wire
